// ==== design/imul_pkg.sv ====
package imul_pkg;

  localparam int xlen = 64;
  localparam int plen = 128;
  localparam int hlen = 32;
  localparam int latency = 4;

  // operands carry one extra bit for the sign/zero extension
  localparam int opw = xlen + 1;

  // radix-4 digits over the 65-bit multiplier, plus one row for negate bits
  localparam int booth_digits = (opw + 1) / 2;
  localparam int pp_rows = booth_digits + 1;

  // side paths skip the compress and final add stages
  localparam int side_depth = latency - 2;

  typedef enum logic [3:0] {
    op_mul64     = 4'd0,
    op_imul64    = 4'd1,
    op_lmul64    = 4'd2,
    op_limul64   = 4'd3,
    op_mul32     = 4'd4,
    op_imul32    = 4'd5,
    op_mul32_64  = 4'd6,
    op_imul32_64 = 4'd7,
    op_swp32     = 4'd8,
    op_swp64     = 4'd9
  } imul_op_e;

  typedef struct packed {
    logic cf;
    logic of;
    logic rsv;
    logic sf;
    logic zf;
    logic pf;
  } imul_flags_t;

  typedef struct packed {
    logic            valid;
    imul_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } imul_req_t;

  typedef struct packed {
    logic valid;
    logic is_signed;
    logic wide;
    logic upper;
    logic short32;
    logic swap;
  } imul_ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] res;
    imul_flags_t     flags;
  } imul_res_t;

endpackage

// ==== design/imul_decode.sv ====
`timescale 1ns/1ps

module imul_decode import imul_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            stall,
  input  imul_req_t       req,
  output imul_ctrl_t      ctrl,
  output logic [opw-1:0]  op_a,
  output logic [opw-1:0]  op_b
);

  imul_ctrl_t     ctrl_d;
  logic [opw-1:0] ext_a;
  logic [opw-1:0] ext_b;

  always_comb begin
    ctrl_d = '0;
    ctrl_d.valid = req.valid;
    case (req.op)
      op_mul64: ctrl_d.wide = 1'b1;
      op_imul64: begin
        ctrl_d.wide = 1'b1;
        ctrl_d.is_signed = 1'b1;
      end
      op_lmul64: begin
        ctrl_d.wide = 1'b1;
        ctrl_d.upper = 1'b1;
      end
      op_limul64: begin
        ctrl_d.wide = 1'b1;
        ctrl_d.is_signed = 1'b1;
        ctrl_d.upper = 1'b1;
      end
      op_mul32: ctrl_d.short32 = 1'b1;
      op_imul32: begin
        ctrl_d.short32 = 1'b1;
        ctrl_d.is_signed = 1'b1;
      end
      op_mul32_64: ctrl_d.is_signed = 1'b0;
      op_imul32_64: ctrl_d.is_signed = 1'b1;
      // swp32 only needs the low word, swp64 the whole operand
      op_swp32: begin
        ctrl_d.swap = 1'b1;
        ctrl_d.short32 = 1'b1;
      end
      op_swp64: begin
        ctrl_d.swap = 1'b1;
        ctrl_d.wide = 1'b1;
      end
      default: ctrl_d.wide = 1'b1;
    endcase
  end

  // 32-bit ops see only the low word
  always_comb begin
    if (ctrl_d.wide) begin
      ext_a = {ctrl_d.is_signed & req.a[xlen-1], req.a};
      ext_b = {ctrl_d.is_signed & req.b[xlen-1], req.b};
    end else begin
      ext_a = {{(opw-hlen){ctrl_d.is_signed & req.a[hlen-1]}}, req.a[hlen-1:0]};
      ext_b = {{(opw-hlen){ctrl_d.is_signed & req.b[hlen-1]}}, req.b[hlen-1:0]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
      op_a <= '0;
      op_b <= '0;
    end else if (!stall) begin
      ctrl <= ctrl_d;
      op_a <= ext_a;
      op_b <= ext_b;
    end
  end

  a_op_known: assert property (@(posedge clk) disable iff (!arst_n)
    req.valid |-> !$isunknown(req.op));

endmodule

// ==== design/imul_compress.sv ====
`timescale 1ns/1ps

module imul_compress import imul_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             stall,
  input  logic [opw-1:0]   op_a,
  input  logic [opw-1:0]   op_b,
  output logic [plen-1:0]  sum_row,
  output logic [plen-1:0]  carry_row
);

  // multiplier with one sign bit on top and the implicit zero below
  logic [opw+1:0]  b_ext;
  logic [plen-1:0] a_ext;
  logic [plen-1:0] pp [pp_rows];
  logic [2:0]      grp;
  logic [plen-1:0] mag;

  assign b_ext = {op_b[opw-1], op_b, 1'b0};
  assign a_ext = {{(plen-opw){op_a[opw-1]}}, op_a};

  // booth recoding, negative digits become ~mag plus a bit in the last row
  always_comb begin
    grp = '0;
    mag = '0;
    pp[pp_rows-1] = '0;
    for (int i = 0; i < booth_digits; i++) begin
      grp = b_ext[2*i +: 3];
      if (grp[1] ^ grp[0]) begin
        mag = a_ext;
      end else if (grp == 3'b100 || grp == 3'b011) begin
        mag = a_ext << 1;
      end else begin
        mag = '0;
      end
      pp[i] = (grp[2] ? ~mag : mag) << (2 * i);
      pp[pp_rows-1][2*i] = grp[2];
    end
  end

  // 3:2 carry-save chain, one new row per step
  for (genvar k = 0; k < pp_rows - 1; k++) begin : g_csa
    logic [plen-1:0] s;
    logic [plen-1:0] c;

    if (k == 0) begin : g_init
      assign s = pp[0];
      assign c = pp[1];
    end else begin : g_add
      logic [plen-1:0] maj;

      assign s = g_csa[k-1].s ^ g_csa[k-1].c ^ pp[k+1];
      assign maj = (g_csa[k-1].s & g_csa[k-1].c) |
                   (g_csa[k-1].s & pp[k+1]) |
                   (g_csa[k-1].c & pp[k+1]);
      assign c = {maj[plen-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_row   <= '0;
      carry_row <= '0;
    end else if (!stall) begin
      sum_row   <= g_csa[pp_rows-2].s;
      carry_row <= g_csa[pp_rows-2].c;
    end
  end

endmodule

// ==== design/imul_final_add.sv ====
`timescale 1ns/1ps

module imul_final_add import imul_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             stall,
  input  logic [plen-1:0]  sum_row,
  input  logic [plen-1:0]  carry_row,
  output logic [plen-1:0]  product
);

  logic [plen-1:0] full_sum;

  // carry out of bit 127 is dropped, the product is taken mod 2^128
  assign full_sum = sum_row + carry_row;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      product <= '0;
    end else if (!stall) begin
      product <= full_sum;
    end
  end

endmodule

// ==== design/imul_flags.sv ====
`timescale 1ns/1ps

module imul_flags import imul_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             stall,
  input  imul_ctrl_t       ctrl,
  input  logic [plen-1:0]  product,
  input  logic [xlen-1:0]  swapped,
  output imul_res_t        rsp
);

  logic [xlen-1:0] res;
  logic            ovf;
  imul_flags_t     flg;

  always_comb begin
    if (ctrl.swap) begin
      res = swapped;
    end else if (ctrl.upper) begin
      res = product[plen-1:xlen];
    end else if (ctrl.short32) begin
      res = {{(xlen-hlen){ctrl.is_signed & product[hlen-1]}}, product[hlen-1:0]};
    end else begin
      res = product[xlen-1:0];
    end
  end

  // product must equal the extension of its low part at the destination width
  always_comb begin
    if (ctrl.short32) begin
      ovf = product[plen-1:hlen] != {(plen-hlen){ctrl.is_signed & product[hlen-1]}};
    end else begin
      ovf = product[plen-1:xlen] != {(plen-xlen){ctrl.is_signed & product[xlen-1]}};
    end
  end

  always_comb begin
    flg = '0;
    if (!ctrl.swap) begin
      flg.cf = ovf;
      flg.of = ovf;
      flg.sf = ctrl.short32 ? res[hlen-1] : res[xlen-1];
      flg.zf = res == '0;
      flg.pf = ~^res[7:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else if (!stall) begin
      rsp.valid <= ctrl.valid;
      rsp.res   <= res;
      rsp.flags <= flg;
    end
  end

endmodule

// ==== design/imul_pipe_delay.sv ====
`timescale 1ns/1ps

module imul_pipe_delay #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     stall,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage_q [depth];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '0;
      end
    end else if (!stall) begin
      stage_q[0] <= din;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[depth-1];

  a_dout_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(dout));

endmodule

// ==== design/imul_unit.sv ====
`timescale 1ns/1ps

module imul_unit import imul_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      stall,
  input  imul_req_t req,
  output imul_res_t rsp
);

  imul_ctrl_t      ctrl_s1;
  imul_ctrl_t      ctrl_s3;
  logic [opw-1:0]  op_a;
  logic [opw-1:0]  op_b;
  logic [plen-1:0] sum_row;
  logic [plen-1:0] carry_row;
  logic [plen-1:0] product;
  logic [xlen-1:0] swap_s1;
  logic [xlen-1:0] swap_s3;

  imul_decode u_decode (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .req    (req),
    .ctrl   (ctrl_s1),
    .op_a   (op_a),
    .op_b   (op_b)
  );

  imul_compress u_compress (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .op_a      (op_a),
    .op_b      (op_b),
    .sum_row   (sum_row),
    .carry_row (carry_row)
  );

  imul_final_add u_final_add (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .sum_row   (sum_row),
    .carry_row (carry_row),
    .product   (product)
  );

  // byte reversal, swp32 keeps the upper word zero
  always_comb begin
    swap_s1 = '0;
    if (ctrl_s1.short32) begin
      for (int i = 0; i < hlen / 8; i++) begin
        swap_s1[8*i +: 8] = op_a[8*(hlen/8-1-i) +: 8];
      end
    end else begin
      for (int i = 0; i < xlen / 8; i++) begin
        swap_s1[8*i +: 8] = op_a[8*(xlen/8-1-i) +: 8];
      end
    end
  end

  imul_pipe_delay #(
    .payload_t (imul_ctrl_t),
    .depth     (side_depth)
  ) ctrl_dly (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .din    (ctrl_s1),
    .dout   (ctrl_s3)
  );

  imul_pipe_delay #(
    .payload_t (logic [xlen-1:0]),
    .depth     (side_depth)
  ) swap_dly (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .din    (swap_s1),
    .dout   (swap_s3)
  );

  imul_flags u_flags (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .ctrl    (ctrl_s3),
    .product (product),
    .swapped (swap_s3),
    .rsp     (rsp)
  );

  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> $stable(rsp.valid));

endmodule

// ==== test/imul_ref.svh ====
`ifndef IMUL_REF_SVH
`define IMUL_REF_SVH

// operand widened to the product width, 32-bit ops use only the low word
function automatic logic [plen-1:0] extend_operand(input logic [xlen-1:0] x,
                                                   input bit sgn, input bit half);
  logic sbit;
  if (half) begin
    sbit = sgn & x[hlen-1];
    return {{(plen-hlen){sbit}}, x[hlen-1:0]};
  end
  sbit = sgn & x[xlen-1];
  return {{(plen-xlen){sbit}}, x};
endfunction

// range check of the full product against a w-bit destination
function automatic bit overflows(input logic [plen-1:0] p, input bit sgn, input int w);
  logic [plen-1:0]        lim;
  logic signed [plen-1:0] top;
  lim = plen'(1) << w;
  top = $signed(lim >> 1);
  if (sgn) begin
    return ($signed(p) >= top) || ($signed(p) < -top);
  end
  return p >= lim;
endfunction

function automatic imul_res_t imul_expect(input imul_op_e op, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
  imul_res_t       e;
  bit              sgn;
  bit              half;
  int              w;
  logic [hlen-1:0] rev32;
  logic [plen-1:0] ea;
  logic [plen-1:0] eb;
  logic [plen-1:0] p;
  e = '0;
  e.valid = 1'b1;
  // swaps leave every flag clear
  if (op == op_swp64) begin
    e.res = {<<8{a}};
    return e;
  end
  if (op == op_swp32) begin
    rev32 = {<<8{a[hlen-1:0]}};
    e.res = {{(xlen-hlen){1'b0}}, rev32};
    return e;
  end
  sgn = op inside {op_imul64, op_limul64, op_imul32, op_imul32_64};
  half = op inside {op_mul32, op_imul32, op_mul32_64, op_imul32_64};
  w = (op == op_mul32 || op == op_imul32) ? hlen : xlen;
  ea = extend_operand(a, sgn, half);
  eb = extend_operand(b, sgn, half);
  if (sgn) begin
    p = $signed(ea) * $signed(eb);
  end else begin
    p = ea * eb;
  end
  if (op == op_lmul64 || op == op_limul64) begin
    e.res = p[plen-1:xlen];
  end else if (w == hlen) begin
    e.res = {{(xlen-hlen){sgn & p[hlen-1]}}, p[hlen-1:0]};
  end else begin
    e.res = p[xlen-1:0];
  end
  e.flags.cf = overflows(p, sgn, w);
  e.flags.of = e.flags.cf;
  e.flags.sf = e.res[w-1];
  e.flags.zf = e.res == '0;
  e.flags.pf = ~^e.res[7:0];
  return e;
endfunction

`endif

// ==== test/tb_imul_unit.sv ====
`timescale 1ns/1ps

module tb_imul_unit import imul_pkg::*; ();

  `include "imul_ref.svh"

  localparam int n_corner = 200;
  localparam int n_random = 400;
  localparam int n_stalled = 400;
  localparam int n_swap = 24;
  localparam int n_ovf = 16;
  localparam int n_gap = 60;
  localparam int n_requests = n_corner + n_random + n_stalled + n_swap + n_ovf + n_gap;

  typedef struct packed {
    imul_op_e    op;
    imul_res_t   res;
    logic [31:0] stamp;
  } expected_t;

  logic        clk;
  logic        arst_n;
  logic        stall;
  imul_req_t   req;
  imul_res_t   rsp;
  int          seed;
  int          stall_pct;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] sf_edge;
  logic        last_stall;
  logic        first_edge;
  imul_res_t   last_rsp;
  expected_t   pending [$];

  imul_unit DUT (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .req    (req),
    .rsp    (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ten cycles per request plus slack for stalls and gaps
  initial begin
    #((n_requests + 50) * 10 * 10);
    $display("watchdog expired with %0d results outstanding", pending.size());
    $display("closing: %0d checks, %0d errors", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] want);
    checks++;
    assert (got === want) else begin
      $display("FAILED t=%0t %s exp=%h got=%h", $time, name, want, got);
      errors++;
    end
  endtask

  always @(posedge clk) begin : compare
    expected_t head;
    if (!arst_n) begin
      sf_edge = '0;
      last_stall = 1'b0;
      first_edge = 1'b1;
    end else begin
      if (first_edge) begin
        checks++;
        assert (rsp.valid === 1'b0) else begin
          $display("rsp.valid was not low right after reset at t=%0t", $time);
          errors++;
        end
        first_edge = 1'b0;
      end
      if (last_stall) begin
        checks++;
        assert (rsp === last_rsp) else begin
          $display("FAILED t=%0t rsp under stall exp=%h got=%h", $time, last_rsp, rsp);
          errors++;
        end
      end
      if (!stall && rsp.valid) begin
        checks++;
        assert (pending.size() != 0) else begin
          $display("result %h appeared at t=%0t with no request outstanding", rsp.res, $time);
          errors++;
        end
        if (pending.size() != 0) begin
          head = pending.pop_front();
          check_value($sformatf("rsp.res (%s)", head.op.name()), rsp.res, head.res.res);
          check_value($sformatf("rsp.flags (%s)", head.op.name()), xlen'(rsp.flags),
                      xlen'(head.res.flags));
          check_value("rsp latency", xlen'(sf_edge - head.stamp), xlen'(latency));
        end
      end
      if (!stall && req.valid) begin
        head.op = req.op;
        head.res = imul_expect(req.op, req.a, req.b);
        head.stamp = sf_edge;
        pending.push_back(head);
      end
      if (!stall) begin
        sf_edge++;
      end
      last_stall = stall;
      last_rsp = rsp;
    end
  end

  // held until a stall-free edge takes it
  task automatic send(input imul_op_e op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    bit held;
    req.valid = 1'b1;
    req.op = op;
    req.a = a;
    req.b = b;
    do begin
      held = stall_pct != 0 && ($unsigned($random(seed)) % 100) < stall_pct;
      stall = held;
      @(negedge clk);
    end while (held);
    req.valid = 1'b0;
  endtask

  task automatic idle(input int n);
    req.valid = 1'b0;
    repeat (n) begin
      stall = stall_pct != 0 && ($unsigned($random(seed)) % 100) < stall_pct;
      @(negedge clk);
    end
    stall = 1'b0;
  endtask

  task automatic corner_sweep();
    logic [xlen-1:0] c64 [5];
    logic [hlen-1:0] c32 [5];
    c64 = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
    c32 = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          // junk in the upper word must not leak into 32-bit ops
          if (k < 4) begin
            send(imul_op_e'(k), c64[i], c64[j]);
          end else begin
            send(imul_op_e'(k), {32'ha5a5_a5a5, c32[i]}, {32'h5a5a_5a5a, c32[j]});
          end
        end
      end
    end
  endtask

  task automatic random_traffic(input int n, input int gap_pct, input bit swaps_only);
    imul_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              gap;
    for (int i = 0; i < n; i++) begin
      if (swaps_only) begin
        op = ($random(seed) & 1) ? op_swp64 : op_swp32;
      end else begin
        op = imul_op_e'($unsigned($random(seed)) % 10);
      end
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      send(op, a, b);
      if (gap_pct != 0 && ($unsigned($random(seed)) % 100) < gap_pct) begin
        gap = 1 + int'($unsigned($random(seed)) % 3);
        idle(gap);
      end
    end
  endtask

  task automatic overflow_pairs();
    send(op_mul64, 64'h1_0000_0000, 64'h1_0000_0000);
    send(op_mul64, 64'hffff_ffff, 64'h1_0000_0001);
    send(op_mul64, '1, 64'h2);
    send(op_imul64, 64'hffff_ffff_8000_0000, 64'h1_0000_0000);
    send(op_imul64, 64'h8000_0000, 64'h1_0000_0000);
    send(op_imul64, '1, 64'h8000_0000_0000_0000);
    send(op_imul64, '1, 64'h7fff_ffff_ffff_ffff);
    send(op_lmul64, 64'h1_0000_0000, 64'h1_0000_0000);
    send(op_limul64, '1, '1);
    send(op_mul32, 64'h1_0000, 64'h1_0000);
    send(op_mul32, 64'hffff, 64'h1_0001);
    send(op_imul32, 64'h8000, 64'h1_0000);
    send(op_imul32, 64'hffff_8000, 64'h1_0000);
    send(op_imul32, 64'hffff_ffff, 64'h8000_0000);
    send(op_mul32_64, 64'hffff_ffff, 64'hffff_ffff);
    send(op_imul32_64, 64'h8000_0000, 64'h8000_0000);
  endtask

  initial begin
    seed = 32'h9a6e;
    stall_pct = 0;
    stall = 1'b0;
    req = '0;
    arst_n = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    idle(2);
    corner_sweep();
    random_traffic(n_random, 0, 1'b0);
    stall_pct = 30;
    random_traffic(n_stalled, 10, 1'b0);
    stall_pct = 0;
    send(op_swp64, 64'h0123_4567_89ab_cdef, 64'h0);
    send(op_swp32, 64'hffff_ffff_0123_4567, 64'h0);
    send(op_swp64, '0, '1);
    send(op_swp32, '1, '0);
    random_traffic(n_swap - 4, 0, 1'b1);
    overflow_pairs();
    random_traffic(n_gap, 40, 1'b0);
    while (pending.size() != 0) begin
      idle(1);
    end
    idle(8);
    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+test
design/imul_pkg.sv
design/imul_decode.sv
design/imul_compress.sv
design/imul_final_add.sv
design/imul_flags.sv
design/imul_pipe_delay.sv
design/imul_unit.sv
test/tb_imul_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_imul_unit -f list.f \
  -Mdir obj_dir -o sim_imul_unit
./obj_dir/sim_imul_unit | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
